/* pwm_timer.f */
verilog/pwm_pkg.sv
verilog/pwm_prescaler.sv
verilog/pwm_counter.sv
verilog/comparator.sv
verilog/pwm_ctrl.sv
verilog/pwm_timer.sv
tests/pwm_timer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the PWM timer testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module pwm_timer_tb -f pwm_timer.f \
	-o pwm_timer_sim \
	&& ./obj_dir/pwm_timer_sim | tee /dev/stderr | grep -q "Testbench passed" \
	&& echo "simulation PASS" && exit 0 \
	|| { echo "simulation FAIL"; exit 1; }

/* tests/pwm_timer_tb.sv */
`timescale 1ns/1ps

module pwm_timer_tb;
	import pwm_pkg::*;

	localparam int cycle_limit = 6000; // five scenarios of about 1000 cycles, plus margin.
	localparam logic [op_bits-1:0] op_hold = 3'd7;

	logic                             clk_i;
	logic                             rstn_i;
	logic                             cmd_start_i;
	logic                             cmd_stop_i;
	logic                             cmd_update_i;
	logic                             cmd_reset_i;
	logic                             cfg_mode_i;
	logic [prescale_bits-1:0]         cfg_prescale_i;
	logic [timer_bits-1:0]            cfg_period_i;
	logic [n_channels*timer_bits-1:0] cfg_thresh_i;
	logic [n_channels*op_bits-1:0]    cfg_op_i;
	logic [timer_bits-1:0]            timer_count_o;
	logic [n_channels-1:0]            pwm_o;
	integer                           seed = 32'h21bc;
	int                               errors = 0;
	int                               timeouts = 0;
	int                               cycles = 0;

	// ====================
	// model state
	// ====================

	logic                     m_active = 1'b0;
	logic                     m_update = 1'b0;
	logic                     m_rst = 1'b0;
	logic                     m_mode = mode_sawtooth;
	logic [prescale_bits-1:0] m_prescale = '0;
	logic [timer_bits-1:0]    m_period = '0;
	logic [prescale_bits-1:0] m_div = '0;
	logic                     m_loaded = 1'b0;
	logic                     m_tick = 1'b0;
	logic [timer_bits-1:0]    m_count = '0;
	logic                     m_down = 1'b0;
	logic                     m_valid = 1'b0;
	logic                     m_end = 1'b0;
	logic                     m_saw = 1'b1;
	logic [timer_bits-1:0]    m_stage_th [n_channels];
	logic [op_bits-1:0]       m_stage_op [n_channels];
	logic [timer_bits-1:0]    m_comp [n_channels] = '{default: '0};
	logic [op_bits-1:0]       m_op [n_channels] = '{default: op_set};
	logic [n_channels-1:0]    m_val = '0;
	logic [n_channels-1:0]    m_second = '0;

	pwm_timer pwm_timer_i (
		.clk_i          (clk_i),
		.rstn_i         (rstn_i),
		.cmd_start_i    (cmd_start_i),
		.cmd_stop_i     (cmd_stop_i),
		.cmd_update_i   (cmd_update_i),
		.cmd_reset_i    (cmd_reset_i),
		.cfg_mode_i     (cfg_mode_i),
		.cfg_prescale_i (cfg_prescale_i),
		.cfg_period_i   (cfg_period_i),
		.cfg_thresh_i   (cfg_thresh_i),
		.cfg_op_i       (cfg_op_i),
		.timer_count_o  (timer_count_o),
		.pwm_o          (pwm_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % $unsigned(n));
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: expected %h, got %h at %0t", name, expected, actual, $time);
		end
	endtask

	// one clock edge of the whole unit, later stages first so each reads old state.
	task automatic model_step();
		logic                     hit;
		logic                     first;
		logic                     second;
		logic [prescale_bits-1:0] left;
		for (int ch = 0; ch < n_channels; ch++) begin
			hit    = m_valid && (m_comp[ch] == m_count);
			first  = (m_op[ch] == op_set_clear);
			if (m_op[ch] == op_toggle_clear || m_op[ch] == op_toggle_set) begin
				first = ~m_val[ch];
			end
			second = (m_op[ch] == op_toggle_set || m_op[ch] == op_clear_set);
			if (m_rst) begin
				m_val[ch]    = 1'b0;
				m_second[ch] = 1'b0;
			end else if (m_valid && m_active) begin
				case (m_op[ch])
					op_set: m_val[ch] = hit ? 1'b1 : m_val[ch];
					op_clear: m_val[ch] = hit ? 1'b0 : m_val[ch];
					op_toggle: m_val[ch] = m_val[ch] ^ hit;
					op_hold: m_second[ch] = 1'b0;
					default: begin
						if (!m_saw) begin
							if (hit) begin
								m_val[ch]    = m_second[ch] ? second : first; // first and second match.
								m_second[ch] = ~m_second[ch];
							end
						end else if (hit) begin
							m_val[ch] = first;
						end else if (m_end) begin
							m_val[ch] = second; // the end strobe is the second event.
						end
					end
				endcase
			end
			if (m_update) begin
				m_comp[ch] = m_stage_th[ch];
				m_op[ch]   = m_stage_op[ch];
			end
		end
		if (m_rst) begin
			m_count = '0;
			m_down  = 1'b0;
			m_valid = 1'b0;
			m_end   = 1'b0;
		end else begin
			m_valid = m_tick;
			m_end   = 1'b0;
			if (m_tick && m_mode == mode_sawtooth) begin
				m_count = (m_count >= m_period) ? '0 : m_count + 1'b1;
				m_down  = 1'b0;
				m_end   = (m_count == m_period);
			end else if (m_tick) begin
				if (m_count != '0 && (m_down || m_count >= m_period)) begin
					m_count = m_count - 1'b1;
					m_down  = 1'b1;
					m_end   = (m_count == '0); // the triangle closes at 0.
				end else begin
					m_count = (m_count < m_period) ? m_count + 1'b1 : m_count;
					m_down  = 1'b0;
				end
			end
		end
		m_saw = (m_mode == mode_sawtooth);
		if (m_rst) begin
			m_div    = '0;
			m_loaded = 1'b0;
			m_tick   = 1'b0;
		end else if (m_active) begin
			left     = m_loaded ? m_div : m_prescale;
			m_loaded = 1'b1;
			m_tick   = (left == '0);
			m_div    = m_tick ? m_prescale : left - 1'b1;
		end else begin
			m_tick = 1'b0;
		end
		m_rst    = cmd_reset_i; // reset beats update, update beats stop, stop beats start.
		m_update = cmd_update_i && !cmd_reset_i;
		if (m_update) begin
			m_mode     = cfg_mode_i;
			m_prescale = cfg_prescale_i;
			m_period   = cfg_period_i;
			for (int ch = 0; ch < n_channels; ch++) begin
				m_stage_th[ch] = cfg_thresh_i[ch*timer_bits +: timer_bits];
				m_stage_op[ch] = cfg_op_i[ch*op_bits +: op_bits];
			end
		end else if (!cmd_reset_i && cmd_stop_i) begin
			m_active = 1'b0;
		end else if (!cmd_reset_i && cmd_start_i) begin
			m_active = 1'b1;
		end
	endtask

	task automatic drive_cycle(input logic start, input logic stop, input logic update,
		input logic reset);
		cmd_start_i  = start;
		cmd_stop_i   = stop;
		cmd_update_i = update;
		cmd_reset_i  = reset;
		@(posedge clk_i);
		model_step();
		@(negedge clk_i);
		check_value("timer_count_o", m_count, timer_count_o);
		check_value("pwm_o", m_val, pwm_o);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
		end
	endtask

	task automatic load_config(input logic mode, input logic [n_channels*op_bits-1:0] ops);
		int per;
		per            = 4 + rand_below(17);
		cfg_mode_i     = mode;
		cfg_prescale_i = prescale_bits'(rand_below(4));
		cfg_period_i   = timer_bits'(per);
		cfg_op_i       = ops;
		for (int ch = 0; ch < n_channels; ch++) begin
			cfg_thresh_i[ch*timer_bits +: timer_bits] = timer_bits'(rand_below(per));
		end
		drive_cycle(1'b0, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic end_run();
		$display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	initial begin
		while (cycles < cycle_limit) begin
			@(posedge clk_i);
			cycles++;
		end
		timeouts++;
		$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
		end_run();
	end

	// ====================
	// scenarios
	// ====================

	initial begin
		rstn_i         = 1'b0;
		cmd_start_i    = 1'b0;
		cmd_stop_i     = 1'b0;
		cmd_update_i   = 1'b0;
		cmd_reset_i    = 1'b0;
		cfg_mode_i     = mode_sawtooth;
		cfg_prescale_i = '0;
		cfg_period_i   = '0;
		cfg_thresh_i   = '0;
		cfg_op_i       = '0;
		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		rstn_i = 1'b1;
		load_config(mode_sawtooth, {op_set, op_toggle, op_clear, op_set});
		drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
		idle_cycles(900);
		drive_cycle(1'b0, 1'b0, 1'b0, 1'b1);
		load_config(mode_sawtooth, {op_clear_set, op_toggle_set, op_set_clear, op_toggle_clear});
		idle_cycles(900);
		drive_cycle(1'b0, 1'b0, 1'b0, 1'b1);
		load_config(mode_updown, {op_toggle, op_set_clear, op_toggle_clear, op_set});
		idle_cycles(500);
		drive_cycle(1'b0, 1'b0, 1'b0, 1'b1);
		load_config(mode_updown, {op_hold, op_clear_set, op_toggle_set, op_clear});
		idle_cycles(500);
		for (int i = 0; i < 2; i++) begin
			drive_cycle(1'b0, 1'b1, 1'b0, 1'b0); // count and outputs hold while stopped.
			idle_cycles(50 + rand_below(100));
			drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
			idle_cycles(200);
		end
		for (int i = 0; i < 2; i++) begin
			drive_cycle(1'b0, 1'b0, 1'b0, 1'b1);
			load_config((i == 1) ? mode_updown : mode_sawtooth, 12'(rand_below(4096)));
			idle_cycles(300);
		end
		for (int i = 0; i < 1000; i++) begin
			cfg_mode_i     = 1'(rand_below(2));
			cfg_prescale_i = prescale_bits'(rand_below(4));
			cfg_period_i   = timer_bits'(rand_below(16));
			cfg_op_i       = 12'(rand_below(4096));
			for (int ch = 0; ch < n_channels; ch++) begin
				cfg_thresh_i[ch*timer_bits +: timer_bits] = timer_bits'(rand_below(16));
			end
			drive_cycle(rand_below(8) == 0, rand_below(24) == 0, rand_below(12) == 0,
				rand_below(40) == 0);
		end
		end_run();
	end

endmodule

/* verilog/comparator.sv */
`timescale 1ns/1ps

module comparator (
	input  logic                           clk_i,
	input  logic                           rstn_i,
	input  logic                           ctrl_active_i,
	input  logic                           ctrl_update_i,
	input  logic                           ctrl_rst_i,
	input  logic [pwm_pkg::timer_bits-1:0] cfg_comp_i,
	input  logic [pwm_pkg::op_bits-1:0]    cfg_comp_op_i,
	input  logic                           timer_end_i,
	input  logic                           timer_valid_i,
	input  logic                           timer_sawtooth_i,
	input  logic [pwm_pkg::timer_bits-1:0] timer_count_i,
	output logic                           result_o
);
	import pwm_pkg::*;

	logic [timer_bits-1:0] comp_q;
	logic [op_bits-1:0]    op_q;
	logic                  value_q;
	logic                  second_q;
	logic                  match;
	logic                  two_event;
	logic                  hold_op;
	logic                  first_val;
	logic                  second_val;

	assign match    = timer_valid_i & (comp_q == timer_count_i);
	assign result_o = value_q;

	// ====================
	// operation decode
	// ====================

	always_comb begin
		two_event  = 1'b1;
		hold_op    = 1'b0;
		first_val  = value_q;
		second_val = value_q;
		case (op_q)
			op_set: begin
				two_event = 1'b0;
				first_val = 1'b1;
			end
			op_toggle_clear: begin
				first_val  = ~value_q;
				second_val = 1'b0;
			end
			op_set_clear: begin
				first_val  = 1'b1;
				second_val = 1'b0;
			end
			op_toggle: begin
				two_event = 1'b0;
				first_val = ~value_q;
			end
			op_clear: begin
				two_event = 1'b0;
				first_val = 1'b0;
			end
			op_toggle_set: begin
				first_val  = ~value_q;
				second_val = 1'b1;
			end
			op_clear_set: begin
				first_val  = 1'b0;
				second_val = 1'b1;
			end
			default: begin
				two_event = 1'b0;
				hold_op   = 1'b1;
			end
		endcase
	end

	// ====================
	// channel state
	// ====================

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			comp_q <= '0;
			op_q   <= op_set;
		end else if (ctrl_update_i) begin
			comp_q <= cfg_comp_i;
			op_q   <= cfg_comp_op_i;
		end
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			value_q  <= 1'b0;
			second_q <= 1'b0;
		end else if (ctrl_rst_i) begin
			value_q  <= 1'b0;
			second_q <= 1'b0;
		end else if (timer_valid_i && ctrl_active_i) begin
			if (hold_op) begin
				second_q <= 1'b0;
			end else if (!two_event) begin
				if (match) begin
					value_q <= first_val;
				end
			end else if (timer_sawtooth_i) begin
				if (match) begin
					value_q <= first_val;
				end else if (timer_end_i) begin // the end strobe is the second event.
					value_q <= second_val;
				end
			end else if (match) begin
				value_q  <= second_q ? second_val : first_val; // matches alternate in up-down mode.
				second_q <= ~second_q;
			end
		end
	end

endmodule

/* verilog/pwm_counter.sv */
`timescale 1ns/1ps

module pwm_counter (
	input  logic                           clk_i,
	input  logic                           rstn_i,
	input  logic                           ctrl_rst_i,
	input  logic                           tick_i,
	input  logic                           mode_i,
	input  logic [pwm_pkg::timer_bits-1:0] period_i,
	output logic [pwm_pkg::timer_bits-1:0] timer_count_o,
	output logic                           timer_valid_o,
	output logic                           timer_end_o,
	output logic                           timer_sawtooth_o
);
	import pwm_pkg::*;

	logic [timer_bits-1:0] count_q;
	logic                  down_q;
	logic [timer_bits-1:0] next_count;
	logic                  next_down;
	logic                  next_end;
	logic                  step_down;

	// ====================
	// next count
	// ====================

	always_comb begin
		// in up-down mode the count turns at the period and keeps going down until 0.
		step_down = (count_q != '0) && (down_q || (count_q >= period_i));
		if (mode_i == mode_updown) begin
			if (step_down) begin
				next_count = count_q - 1'b1;
			end else if (count_q < period_i) begin
				next_count = count_q + 1'b1;
			end else begin
				next_count = count_q; // a zero period keeps the count at 0.
			end
			next_down = step_down;
			next_end  = step_down && (next_count == '0); // the triangle ends on reaching 0.
		end else begin
			if (count_q >= period_i) begin
				next_count = '0;
			end else begin
				next_count = count_q + 1'b1;
			end
			next_down = 1'b0;
			next_end  = (next_count == period_i); // the sawtooth ends on showing the period.
		end
	end

	// ====================
	// registered state
	// ====================

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			count_q          <= '0;
			down_q           <= 1'b0;
			timer_valid_o    <= 1'b0;
			timer_end_o      <= 1'b0;
			timer_sawtooth_o <= 1'b1;
		end else begin
			timer_sawtooth_o <= (mode_i == mode_sawtooth); // kept aligned with the count.
			if (ctrl_rst_i) begin
				count_q       <= '0;
				down_q        <= 1'b0;
				timer_valid_o <= 1'b0;
				timer_end_o   <= 1'b0;
			end else begin
				timer_valid_o <= tick_i; // count and valid change on the same edge.
				timer_end_o   <= tick_i & next_end;
				if (tick_i) begin
					count_q <= next_count;
					down_q  <= next_down;
				end
			end
		end
	end

	assign timer_count_o = count_q;

endmodule

/* verilog/pwm_ctrl.sv */
`timescale 1ns/1ps

module pwm_ctrl (
	input  logic                              clk_i,
	input  logic                              rstn_i,
	input  logic                              cmd_start_i,
	input  logic                              cmd_stop_i,
	input  logic                              cmd_update_i,
	input  logic                              cmd_reset_i,
	input  logic                              cfg_mode_i,
	input  logic [pwm_pkg::prescale_bits-1:0] cfg_prescale_i,
	input  logic [pwm_pkg::timer_bits-1:0]    cfg_period_i,
	output logic                              ctrl_active_o,
	output logic                              ctrl_update_o,
	output logic                              ctrl_rst_o,
	output logic                              mode_o,
	output logic [pwm_pkg::prescale_bits-1:0] prescale_o,
	output logic [pwm_pkg::timer_bits-1:0]    period_o
);
	import pwm_pkg::*;

	logic do_update;
	logic do_stop;
	logic do_start;

	// ====================
	// command priority
	// ====================

	// Only the strongest command of a cycle acts: reset, update, stop, start.
	assign do_update = cmd_update_i & ~cmd_reset_i;
	assign do_stop   = cmd_stop_i & ~cmd_update_i & ~cmd_reset_i;
	assign do_start  = cmd_start_i & ~cmd_stop_i & ~cmd_update_i & ~cmd_reset_i;

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			ctrl_active_o <= 1'b0;
			ctrl_update_o <= 1'b0;
			ctrl_rst_o    <= 1'b0;
		end else begin
			ctrl_update_o <= do_update; // one-cycle pulse.
			ctrl_rst_o    <= cmd_reset_i; // one-cycle pulse.
			if (do_stop) begin
				ctrl_active_o <= 1'b0;
			end else if (do_start) begin
				ctrl_active_o <= 1'b1;
			end
		end
	end

	// ====================
	// shadow configuration
	// ====================

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			mode_o     <= mode_sawtooth;
			prescale_o <= '0;
			period_o   <= '0;
		end else if (do_update) begin
			mode_o     <= cfg_mode_i; // inputs may change freely until the next update.
			prescale_o <= cfg_prescale_i;
			period_o   <= cfg_period_i;
		end
	end

endmodule

/* verilog/pwm_pkg.sv */
package pwm_pkg;

	// ====================
	// widths and sizes
	// ====================

	localparam int timer_bits    = 16; // counter and threshold width.
	localparam int prescale_bits = 8;  // prescale value width.
	localparam int n_channels    = 4;  // comparator channels on the shared counter.
	localparam int op_bits       = 3;

	// ====================
	// counter modes
	// ====================

	localparam logic mode_sawtooth = 1'b0; // count up to the period, then wrap to 0.
	localparam logic mode_updown   = 1'b1; // count up to the period, then back down to 0.

	// ====================
	// channel operations
	// ====================

	// The two-part codes act first on a threshold match and then on the second event.
	localparam logic [op_bits-1:0] op_set          = 3'd0;
	localparam logic [op_bits-1:0] op_toggle_clear = 3'd1;
	localparam logic [op_bits-1:0] op_set_clear    = 3'd2;
	localparam logic [op_bits-1:0] op_toggle       = 3'd3;
	localparam logic [op_bits-1:0] op_clear        = 3'd4;
	localparam logic [op_bits-1:0] op_toggle_set   = 3'd5;
	localparam logic [op_bits-1:0] op_clear_set    = 3'd6;

	// code 7 holds the output and clears the second-event flag.

endpackage

/* verilog/pwm_prescaler.sv */
`timescale 1ns/1ps

module pwm_prescaler (
	input  logic                              clk_i,
	input  logic                              rstn_i,
	input  logic                              ctrl_active_i,
	input  logic                              ctrl_rst_i,
	input  logic [pwm_pkg::prescale_bits-1:0] prescale_i,
	output logic                              tick_o
);
	import pwm_pkg::*;

	logic [prescale_bits-1:0] div_q;
	logic                     loaded_q;
	logic [prescale_bits-1:0] div_now;

	// a fresh run starts from the full prescale value.
	assign div_now = loaded_q ? div_q : prescale_i;

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			div_q    <= '0;
			loaded_q <= 1'b0;
			tick_o   <= 1'b0;
		end else if (ctrl_rst_i) begin
			div_q    <= '0;
			loaded_q <= 1'b0;
			tick_o   <= 1'b0;
		end else if (ctrl_active_i) begin
			loaded_q <= 1'b1;
			if (div_now == '0) begin
				div_q  <= prescale_i; // reload for the next tick period.
				tick_o <= 1'b1;
			end else begin
				div_q  <= div_now - 1'b1;
				tick_o <= 1'b0;
			end
		end else begin
			tick_o <= 1'b0; // the divider holds its value while stopped.
		end
	end

endmodule

/* verilog/pwm_timer.sv */
`timescale 1ns/1ps

module pwm_timer (
	input  logic                                              clk_i,
	input  logic                                              rstn_i,
	input  logic                                              cmd_start_i,
	input  logic                                              cmd_stop_i,
	input  logic                                              cmd_update_i,
	input  logic                                              cmd_reset_i,
	input  logic                                              cfg_mode_i,
	input  logic [pwm_pkg::prescale_bits-1:0]                 cfg_prescale_i,
	input  logic [pwm_pkg::timer_bits-1:0]                    cfg_period_i,
	input  logic [pwm_pkg::n_channels*pwm_pkg::timer_bits-1:0] cfg_thresh_i,
	input  logic [pwm_pkg::n_channels*pwm_pkg::op_bits-1:0]    cfg_op_i,
	output logic [pwm_pkg::timer_bits-1:0]                    timer_count_o,
	output logic [pwm_pkg::n_channels-1:0]                    pwm_o
);
	import pwm_pkg::*;

	logic                         ctrl_active;
	logic                         ctrl_update;
	logic                         ctrl_rst;
	logic                         mode;
	logic [prescale_bits-1:0]     prescale;
	logic [timer_bits-1:0]        period;
	logic                         tick;
	logic [timer_bits-1:0]        timer_count;
	logic                         timer_valid;
	logic                         timer_end;
	logic                         timer_sawtooth;
	logic [n_channels*timer_bits-1:0] thresh_q;
	logic [n_channels*op_bits-1:0]    op_q;

	// channel settings wait here until ctrl_update hands them to the comparators.
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			thresh_q <= '0;
			op_q     <= '0;
		end else if (cmd_update_i && !cmd_reset_i) begin
			thresh_q <= cfg_thresh_i;
			op_q     <= cfg_op_i;
		end
	end

	pwm_ctrl pwm_ctrl_i (
		.clk_i          (clk_i),
		.rstn_i         (rstn_i),
		.cmd_start_i    (cmd_start_i),
		.cmd_stop_i     (cmd_stop_i),
		.cmd_update_i   (cmd_update_i),
		.cmd_reset_i    (cmd_reset_i),
		.cfg_mode_i     (cfg_mode_i),
		.cfg_prescale_i (cfg_prescale_i),
		.cfg_period_i   (cfg_period_i),
		.ctrl_active_o  (ctrl_active),
		.ctrl_update_o  (ctrl_update),
		.ctrl_rst_o     (ctrl_rst),
		.mode_o         (mode),
		.prescale_o     (prescale),
		.period_o       (period)
	);

	pwm_prescaler pwm_prescaler_i (
		.clk_i         (clk_i),
		.rstn_i        (rstn_i),
		.ctrl_active_i (ctrl_active),
		.ctrl_rst_i    (ctrl_rst),
		.prescale_i    (prescale),
		.tick_o        (tick)
	);

	pwm_counter pwm_counter_i (
		.clk_i            (clk_i),
		.rstn_i           (rstn_i),
		.ctrl_rst_i       (ctrl_rst),
		.tick_i           (tick),
		.mode_i           (mode),
		.period_i         (period),
		.timer_count_o    (timer_count),
		.timer_valid_o    (timer_valid),
		.timer_end_o      (timer_end),
		.timer_sawtooth_o (timer_sawtooth)
	);

	for (genvar ch = 0; ch < n_channels; ch++) begin : gen_channel
		comparator comparator_i (
			.clk_i            (clk_i),
			.rstn_i           (rstn_i),
			.ctrl_active_i    (ctrl_active),
			.ctrl_update_i    (ctrl_update),
			.ctrl_rst_i       (ctrl_rst),
			.cfg_comp_i       (thresh_q[ch*timer_bits +: timer_bits]),
			.cfg_comp_op_i    (op_q[ch*op_bits +: op_bits]),
			.timer_end_i      (timer_end),
			.timer_valid_i    (timer_valid),
			.timer_sawtooth_i (timer_sawtooth),
			.timer_count_i    (timer_count),
			.result_o         (pwm_o[ch])
		);
	end

	assign timer_count_o = timer_count;

endmodule
